//--- Makefile
SOURCES := files.f $(wildcard logic/*.sv logic/*.svh bench/*.sv)

.PHONY: run clean

obj_dir/Vtb_extender_subsystem: $(SOURCES)
	verilator --binary --assert --timescale 1ns/10ps -f files.f \
		--top-module tb_extender_subsystem -Mdir obj_dir -o Vtb_extender_subsystem

run: obj_dir/Vtb_extender_subsystem
	./obj_dir/Vtb_extender_subsystem

clean:
	rm -rf obj_dir

//--- bench/tb_extender_subsystem.sv
`timescale 1ns/10ps
`include "stream_macros.svh"

module tb_extender_subsystem;

    localparam int PERIOD          = 20;
    localparam int RESET_CYCLES    = 3;
    localparam int STIMULUS_CYCLES = 3000;
    localparam int TIMEOUT_CYCLES  = 4000;
    localparam int DRAIN_CYCLES    = 2 * PERIOD + 2 * `MERGE_FIFO_DEPTH;
    localparam int N_CHANNELS      = `EXT_N_CHANNELS;
    localparam int ADDRESS_BITS    = $bits(stream_pkg::address_t);
    localparam int DEST_BITS       = $bits(stream_pkg::dest_t);

    logic                     clock;
    logic                     arst_n;
    stream_pkg::stream_beat_t in_beat;
    stream_pkg::address_t     repeat_table [`EXT_N_REPEAT];
    stream_pkg::period_t      period;
    stream_pkg::stream_beat_t out_beat;
    logic                     overflow;

    integer                   seed;
    int                       cycle_count;
    int                       drain_count;
    // Rising edges seen since reset was released
    int                       edge_count;
    stream_pkg::stream_beat_t expected_pass [$];
    stream_pkg::stream_beat_t shared_ref;
    logic                     shared_pending;
    int                       shared_edge;
    int                       burst_pos;

    extender_subsystem i_dut (
        .clock        (clock),
        .arst_n       (arst_n),
        .in_beat      (in_beat),
        .repeat_table (repeat_table),
        .period       (period),
        .out_beat     (out_beat),
        .overflow     (overflow)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic check_value(input string what, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
            $display("TB FAILED");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    function automatic logic is_table_address(input stream_pkg::address_t address);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < `EXT_N_REPEAT; i++) begin
            if (address == repeat_table[i]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic stream_pkg::address_t pick_pass_address();
        logic [31:0]          rnd;
        stream_pkg::address_t address;
        rnd     = $random(seed);
        address = rnd[ADDRESS_BITS-1:0];
        while (is_table_address(address)) begin
            address = address + 1'b1;
        end
        return address;
    endfunction

    // Output beats are told apart by address, pass beats never use table addresses
    task automatic check_outputs();
        stream_pkg::address_t     out_address;
        stream_pkg::channel_t     out_channel;
        stream_pkg::stream_beat_t expected;
        out_address = out_beat.dest[ADDRESS_BITS-1:0];
        out_channel = out_beat.dest[DEST_BITS-1:ADDRESS_BITS];
        check_value("overflow", 64'(overflow), 64'd0);
        if (edge_count <= 1) begin
            check_value("out_beat.valid around reset", 64'(out_beat.valid), 64'd0);
        end
        if (!out_beat.valid) begin
            check_value("gap inside a copy burst", 64'(burst_pos), 64'd0);
        end else if (is_table_address(out_address)) begin
            check_value("copy without a pending shared beat", 64'(shared_pending), 64'd1);
            check_value("copy channel", 64'(out_channel), 64'(burst_pos));
            check_value("copy address", 64'(out_address),
                        64'(shared_ref.dest[ADDRESS_BITS-1:0]));
            check_value("copy data", 64'(out_beat.data), 64'(shared_ref.data));
            check_value("copy user", 64'(out_beat.user), 64'(shared_ref.user));
            check_value("copy last", 64'(out_beat.last), 64'(burst_pos == N_CHANNELS - 1));
            if (burst_pos == 0) begin
                // Triggers follow rising edges period, 2*period and so on after reset,
                // the extender and the merger each add one register stage
                check_value("first copy off the trigger grid",
                            64'((edge_count - 2) % PERIOD), 64'd0);
                check_value("first copy before the first trigger",
                            64'(edge_count >= PERIOD + 2), 64'd1);
                check_value("burst start too late",
                            64'(edge_count - shared_edge <= PERIOD + 3), 64'd1);
            end
            if (burst_pos == N_CHANNELS - 1) begin
                burst_pos      = 0;
                shared_pending = 1'b0;
            end else begin
                burst_pos = burst_pos + 1;
            end
        end else begin
            check_value("pass beat inside a copy burst", 64'(burst_pos), 64'd0);
            check_value("pass beat with none expected", 64'(expected_pass.size() != 0), 64'd1);
            expected = expected_pass.pop_front();
            check_value("pass data", 64'(out_beat.data), 64'(expected.data));
            check_value("pass user", 64'(out_beat.user), 64'(expected.user));
            check_value("pass dest", 64'(out_beat.dest), 64'(expected.dest));
            check_value("pass last", 64'(out_beat.last), 64'(expected.last));
        end
    endtask

    // Outputs are sampled on the falling edge, where they are stable
    task automatic step();
        @(negedge clock);
        cycle_count = cycle_count + 1;
        if (arst_n) begin
            edge_count = edge_count + 1;
        end
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("TB FAILED");
            $fatal(1, "Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
        check_outputs();
    endtask

    task automatic drive_beat();
        logic [31:0]              rnd;
        stream_pkg::stream_beat_t beat;
        beat = '0;
        rnd  = $random(seed);
        if (rnd[0]) begin
            beat.valid = 1'b1;
            beat.data  = $random(seed);
            beat.user  = $random(seed);
            rnd        = $random(seed);
            beat.last  = rnd[0];
            // A new shared beat only once the previous burst has been seen
            if (!shared_pending && rnd[2:1] == 2'b00) begin
                beat.dest      = {rnd[4:3], repeat_table[rnd[5]]};
                shared_pending = 1'b1;
                shared_ref     = beat;
                shared_edge    = edge_count + 1;
            end else begin
                beat.dest = {rnd[4:3], pick_pass_address()};
                expected_pass.push_back(beat);
            end
        end
        in_beat = beat;
    endtask

    initial begin
        seed            = 40;
        cycle_count     = 0;
        drain_count     = 0;
        edge_count      = 0;
        shared_pending  = 1'b0;
        shared_edge     = 0;
        burst_pos       = 0;
        shared_ref      = '0;
        arst_n          = 1'b0;
        in_beat         = '0;
        period          = stream_pkg::period_t'(PERIOD);
        repeat_table[0] = 14'h0123;
        repeat_table[1] = 14'h2abc;

        repeat (RESET_CYCLES) step();
        arst_n = 1'b1;

        repeat (STIMULUS_CYCLES) begin
            step();
            drive_beat();
        end
        step();
        in_beat = '0;

        // Drain until the model holds nothing or the drain limit is reached
        while ((expected_pass.size() != 0 || shared_pending) && drain_count < DRAIN_CYCLES) begin
            step();
            drain_count = drain_count + 1;
        end
        // A few more cycles catch stray beats
        repeat (4) step();

        if (expected_pass.size() == 0 && !shared_pending) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("TB FAILED");
            $fatal(1, "Expected beats are still outstanding at the end of the run");
        end
    end

endmodule

//--- files.f
+incdir+logic
logic/stream_pkg.sv
logic/trigger_timer.sv
logic/dest_router.sv
logic/multichannel_extender.sv
logic/stream_merger.sv
logic/extender_subsystem.sv
bench/tb_extender_subsystem.sv

//--- logic/dest_router.sv
`timescale 1ns/10ps
`include "stream_macros.svh"

module dest_router (
    input  logic                     clock,
    input  logic                     arst_n,
    input  stream_pkg::stream_beat_t in_beat,
    input  stream_pkg::address_t     repeat_table [`EXT_N_REPEAT],
    output stream_pkg::stream_beat_t shared_beat,
    output stream_pkg::stream_beat_t pass_beat
);

    localparam int ADDRESS_BITS = $bits(stream_pkg::address_t);

    stream_pkg::address_t     in_address;
    logic                     table_hit;
    logic                     shared_valid;
    logic                     pass_valid;
    stream_pkg::stream_beat_t beat_q;

    assign in_address = in_beat.dest[ADDRESS_BITS-1:0];

    // The channel bits of the incoming dest take no part in the match
    always_comb begin
        table_hit = 1'b0;
        for (int i = 0; i < `EXT_N_REPEAT; i++) begin
            if (in_address == repeat_table[i]) begin
                table_hit = 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            shared_valid <= 1'b0;
            pass_valid   <= 1'b0;
        end else begin
            shared_valid <= in_beat.valid && table_hit;
            pass_valid   <= in_beat.valid && !table_hit;
        end
    end

    // Payload is shared by both outputs, only the valid bits steer it
    always_ff @(posedge clock) begin
        if (in_beat.valid) begin
            beat_q <= in_beat;
        end
    end

    always_comb begin
        shared_beat       = beat_q;
        shared_beat.valid = shared_valid;
        pass_beat         = beat_q;
        pass_beat.valid   = pass_valid;
    end

    // Every input beat lands on exactly one output, one cycle later
    a_one_output: assert property (
        @(posedge clock) disable iff (!arst_n)
        in_beat.valid |=> (shared_beat.valid ^ pass_beat.valid)
    );

endmodule

//--- logic/extender_subsystem.sv
`timescale 1ns/10ps
`include "stream_macros.svh"

module extender_subsystem (
    input  logic                     clock,
    input  logic                     arst_n,
    input  stream_pkg::stream_beat_t in_beat,
    input  stream_pkg::address_t     repeat_table [`EXT_N_REPEAT],
    input  stream_pkg::period_t      period,
    output stream_pkg::stream_beat_t out_beat,
    output logic                     overflow
);

    logic                     trigger;
    stream_pkg::stream_beat_t shared_beat;
    stream_pkg::stream_beat_t pass_beat;
    stream_pkg::stream_beat_t ext_beat;

    trigger_timer i_trigger_timer (
        .clock   (clock),
        .arst_n  (arst_n),
        .period  (period),
        .trigger (trigger)
    );

    // Splits shared values off the main stream
    dest_router i_dest_router (
        .clock        (clock),
        .arst_n       (arst_n),
        .in_beat      (in_beat),
        .repeat_table (repeat_table),
        .shared_beat  (shared_beat),
        .pass_beat    (pass_beat)
    );

    multichannel_extender i_multichannel_extender (
        .clock       (clock),
        .arst_n      (arst_n),
        .trigger     (trigger),
        .shared_beat (shared_beat),
        .ext_beat    (ext_beat)
    );

    // Copy bursts take priority over buffered ordinary beats
    stream_merger i_stream_merger (
        .clock     (clock),
        .arst_n    (arst_n),
        .ext_beat  (ext_beat),
        .pass_beat (pass_beat),
        .out_beat  (out_beat),
        .overflow  (overflow)
    );

endmodule

//--- logic/multichannel_extender.sv
`timescale 1ns/10ps
`include "stream_macros.svh"

module multichannel_extender (
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic                     trigger,
    input  stream_pkg::stream_beat_t shared_beat,
    output stream_pkg::stream_beat_t ext_beat
);

    localparam int LAST_CHANNEL = `EXT_N_CHANNELS - 1;
    localparam int ADDRESS_BITS = $bits(stream_pkg::address_t);
    localparam int DEST_BITS    = $bits(stream_pkg::dest_t);

    stream_pkg::extender_state_t state;
    stream_pkg::channel_t        channel;
    stream_pkg::address_t        latched_address;
    stream_pkg::data_t           latched_data;
    stream_pkg::data_t           latched_user;
    logic                        final_copy;
    logic                        accept;

    assign final_copy = (channel == stream_pkg::channel_t'(LAST_CHANNEL));

    // Shared beats are only taken when no burst is pending
    assign accept = (state == stream_pkg::idle) && shared_beat.valid;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state   <= stream_pkg::idle;
            channel <= '0;
        end else begin
            case (state)
                stream_pkg::idle: begin
                    if (accept) begin
                        // A trigger in the same cycle starts the burst right away
                        if (trigger) begin
                            state <= stream_pkg::extending;
                        end else begin
                            state <= stream_pkg::wait_trigger;
                        end
                    end
                end
                stream_pkg::wait_trigger: begin
                    if (trigger) begin
                        state <= stream_pkg::extending;
                    end
                end
                stream_pkg::extending: begin
                    if (final_copy) begin
                        channel <= '0;
                        state   <= stream_pkg::idle;
                    end else begin
                        channel <= channel + 1'b1;
                    end
                end
                default: begin
                    state <= stream_pkg::idle;
                end
            endcase
        end
    end

    // The incoming last flag is dropped, copies carry their own
    always_ff @(posedge clock) begin
        if (accept) begin
            latched_address <= shared_beat.dest[ADDRESS_BITS-1:0];
            latched_data    <= shared_beat.data;
            latched_user    <= shared_beat.user;
        end
    end

    // Copies are decoded from registers only, so the output has no input path
    always_comb begin
        ext_beat = '0;
        if (state == stream_pkg::extending) begin
            ext_beat.valid = 1'b1;
            ext_beat.data  = latched_data;
            ext_beat.user  = latched_user;
            ext_beat.dest  = {channel, latched_address};
            ext_beat.last  = final_copy;
        end
    end

    // A burst only starts on a trigger and then runs without gaps
    a_valid_in_extending: assert property (
        @(posedge clock) disable iff (!arst_n)
        ext_beat.valid |-> (state == stream_pkg::extending)
            && ($past(state) == stream_pkg::extending || $past(trigger))
    );

    // Last closes a contiguous burst on the final channel
    a_last_on_final: assert property (
        @(posedge clock) disable iff (!arst_n)
        ext_beat.last |-> ext_beat.valid
            && (ext_beat.dest[DEST_BITS-1:ADDRESS_BITS] == stream_pkg::channel_t'(LAST_CHANNEL))
            && $past(ext_beat.valid)
            ##1 !ext_beat.valid
    );

endmodule

//--- logic/stream_macros.svh
`ifndef STREAM_MACROS_SVH
`define STREAM_MACROS_SVH

// Width of the data and user words of a stream beat
`define STREAM_DATA_WIDTH 32

// Width of the full destination word, channel field included
`define STREAM_DEST_WIDTH 16

// Number of copies sent for every shared beat
`define EXT_N_CHANNELS 4

// Channel field in the top bits of dest
`define EXT_CHANNEL_BITS 2

// Entries in the table of shared addresses
`define EXT_N_REPEAT 2

// Pass-through buffer depth in the merger
`define MERGE_FIFO_DEPTH 8

// Width of the trigger period counter
`define TIMER_WIDTH 16

`endif

//--- logic/stream_merger.sv
`timescale 1ns/10ps
`include "stream_macros.svh"

module stream_merger (
    input  logic                     clock,
    input  logic                     arst_n,
    input  stream_pkg::stream_beat_t ext_beat,
    input  stream_pkg::stream_beat_t pass_beat,
    output stream_pkg::stream_beat_t out_beat,
    output logic                     overflow
);

    localparam int DEPTH   = `MERGE_FIFO_DEPTH;
    localparam int PTR_W   = $clog2(DEPTH);
    localparam int COUNT_W = $clog2(DEPTH + 1);

    stream_pkg::stream_beat_t fifo_mem [DEPTH];
    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         rd_ptr;
    logic [COUNT_W-1:0]       count;

    logic                     fifo_empty;
    logic                     fifo_full;
    logic                     bypass;
    logic                     fifo_write;
    logic                     fifo_pop;
    logic                     out_valid;
    stream_pkg::stream_beat_t out_payload;

    assign fifo_empty = (count == '0);
    assign fifo_full  = (count == COUNT_W'(DEPTH));

    // With an empty buffer and no copy in flight a pass beat goes straight out
    assign bypass     = pass_beat.valid && !ext_beat.valid && fifo_empty;
    assign fifo_pop   = !ext_beat.valid && !fifo_empty;
    assign fifo_write = pass_beat.valid && !bypass && !fifo_full;

    always_ff @(posedge clock) begin
        if (fifo_write) begin
            fifo_mem[wr_ptr] <= pass_beat;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (fifo_write) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (fifo_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({fifo_write, fifo_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Sticky, a dropped beat cannot be recovered
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            overflow <= 1'b0;
        end else if (pass_beat.valid && !bypass && fifo_full) begin
            overflow <= 1'b1;
        end
    end

    // Copies win, then the oldest buffered beat, then the bypass
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= ext_beat.valid || fifo_pop || bypass;
        end
    end

    always_ff @(posedge clock) begin
        if (ext_beat.valid) begin
            out_payload <= ext_beat;
        end else if (fifo_pop) begin
            out_payload <= fifo_mem[rd_ptr];
        end else if (bypass) begin
            out_payload <= pass_beat;
        end
    end

    always_comb begin
        out_beat       = out_payload;
        out_beat.valid = out_valid;
    end

    // A pass beat that cannot bypass must find a free slot in the buffer
    a_no_write_full: assert property (
        @(posedge clock) disable iff (!arst_n)
        (pass_beat.valid && !bypass) |-> !fifo_full
    );

endmodule

//--- logic/stream_pkg.sv
`include "stream_macros.svh"

package stream_pkg;

    // Data and user words share one width
    typedef logic [`STREAM_DATA_WIDTH-1:0] data_t;

    typedef logic [`STREAM_DEST_WIDTH-1:0] dest_t;

    // The address is the lower part of dest, the channel the upper part
    typedef logic [`STREAM_DEST_WIDTH-`EXT_CHANNEL_BITS-1:0] address_t;
    typedef logic [`EXT_CHANNEL_BITS-1:0] channel_t;

    typedef logic [`TIMER_WIDTH-1:0] period_t;

    // One beat of the control stream, valid for a single cycle
    typedef struct packed {
        logic  valid;
        data_t data;
        data_t user;
        dest_t dest;
        logic  last;
    } stream_beat_t;

    typedef enum logic [1:0] {
        idle         = 2'd0,
        wait_trigger = 2'd1,
        extending    = 2'd2
    } extender_state_t;

endpackage

//--- logic/trigger_timer.sv
`timescale 1ns/10ps

module trigger_timer (
    input  logic                clock,
    input  logic                arst_n,
    input  stream_pkg::period_t period,
    output logic                trigger
);

    // Counts down from period to 1, then reloads
    stream_pkg::period_t count;

    // A count of zero only exists out of reset and forces the first load
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else begin
            if (count <= stream_pkg::period_t'(1)) begin
                count <= period;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // Trigger is high in the cycle where the counter holds 1
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            trigger <= 1'b0;
        end else begin
            trigger <= (count == stream_pkg::period_t'(2));
        end
    end

    // Periods shorter than two would never let the count reach 2
    a_period_min: assert property (
        @(posedge clock) disable iff (!arst_n)
        (count <= stream_pkg::period_t'(1)) |-> (period >= stream_pkg::period_t'(2))
    );

endmodule
